// File: coco_kbd.f
rtl/coco_kbd_pkg.sv
rtl/kbd_event_capture.sv
rtl/kbd_scancode_map.sv
rtl/key_matrix.sv
rtl/fn_key_tracker.sv
rtl/matrix_scan.sv
rtl/coco_keyboard.sv
sim/coco_keyboard_assert.sv
sim/tb_coco_keyboard.sv

// File: Bender.yml
package:
  name: coco_kbd

sources:
  - rtl/coco_kbd_pkg.sv
  - rtl/kbd_event_capture.sv
  - rtl/kbd_scancode_map.sv
  - rtl/key_matrix.sv
  - rtl/fn_key_tracker.sv
  - rtl/matrix_scan.sv
  - rtl/coco_keyboard.sv
  - target: simulation
    files:
      - sim/coco_keyboard_assert.sv
      - sim/tb_coco_keyboard.sv

// File: sim/kbd_trace.txt
# code pressed event addr dragon joy1 joy2 hilo exp_rows exp_fn exp_modif
# all hex; event 1 flips the toggle, scan inputs apply once the event has settled
00 0 0 00 0 0 0 0 7F 000 0
00 0 0 FF 0 0 0 1 FF 000 0
1C 1 1 FE 0 0 0 1 FF 000 0
00 0 0 FD 0 0 0 1 FE 000 0
00 0 0 FD 1 0 0 1 FB 000 0
1C 0 1 FD 0 0 0 1 FF 000 0
2E 1 1 DF 0 0 0 0 6F 000 0
00 0 0 DF 1 0 0 0 7E 000 0
2E 0 1 00 1 0 0 0 7F 000 0
1D 1 1 7F 1 0 0 1 EF 000 0
1D 0 1 7F 1 0 0 1 FF 000 0
7C 1 1 7F 0 0 0 1 BF 000 0
00 0 0 FB 0 0 0 1 DF 000 0
7C 0 1 00 0 0 0 1 FF 000 0
05 1 1 FF 0 0 0 1 FF 001 0
78 1 1 FF 0 0 0 1 FF 401 0
11 1 1 FF 0 0 0 1 FF 401 2
14 1 1 FF 0 0 0 1 FF 401 6
59 1 1 7F 0 0 0 1 BF 401 7
00 0 0 7F 1 0 0 1 BF 401 7
05 0 1 FF 0 0 0 1 FF 400 7
11 0 1 FF 0 0 0 1 FF 400 5
59 0 1 7F 0 0 0 1 FF 400 4
14 0 1 FF 0 0 0 1 FF 400 0
78 0 1 FF 0 0 0 1 FF 000 0
00 0 0 FF 0 1 0 1 FD 000 0
00 0 0 00 0 0 1 0 7E 000 0
00 0 0 FF 1 1 1 1 FC 000 0
52 1 1 00 0 0 0 1 FF 000 0
52 0 1 00 0 0 0 1 FF 000 0

// File: sim/tb_coco_keyboard.sv
`timescale 1ns/1ps
`default_nettype none

module tb_coco_keyboard;

	localparam int    CLK_PERIOD   = 10;
	localparam int    RESET_CYCLES = 16;
	localparam int    MAX_STEPS    = 64;
	localparam string TRACE_FILE   = "sim/kbd_trace.txt";

	logic                      clk_sys;
	logic                      rst_n;
	logic [10:0]               ps2_key;
	coco_kbd_pkg::matrix_row_t addr;
	logic                      dragon;
	logic                      joy1_fire;
	logic                      joy2_fire;
	logic                      joy_hilo;
	coco_kbd_pkg::matrix_row_t kb_rows;
	coco_kbd_pkg::fn_keys_t    fn_keys;
	coco_kbd_pkg::modif_t      modif;

	// Trace columns code pressed event addr dragon joy1 joy2 hilo rows fn modif
	logic [31:0] steps [MAX_STEPS][11];
	int          num_steps = 0;
	int          cycle_limit = 0;  // Armed once the trace is loaded
	int          cycle_count = 0;
	logic        toggle;           // Event toggle as last driven

	coco_keyboard dut0 (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ps2_key   (ps2_key),
		.addr      (addr),
		.dragon    (dragon),
		.joy1_fire (joy1_fire),
		.joy2_fire (joy2_fire),
		.joy_hilo  (joy_hilo),
		.kb_rows   (kb_rows),
		.fn_keys   (fn_keys),
		.modif     (modif)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	////////////////////
	// Watchdog
	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Run did not finish within %0d cycles", cycle_limit);
			$display("tests failed");
			$fatal(1, "Watchdog expired");
		end
	end

	task automatic check_value(input string name, input logic [15:0] got,
	                           input logic [15:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic load_trace();
		int    fd;
		int    n;
		string line;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open stimulus file %s", TRACE_FILE);
			$display("tests failed");
			$fatal(1, "No stimulus");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;  // Blank or comment
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
				steps[num_steps][0], steps[num_steps][1], steps[num_steps][2],
				steps[num_steps][3], steps[num_steps][4], steps[num_steps][5],
				steps[num_steps][6], steps[num_steps][7], steps[num_steps][8],
				steps[num_steps][9], steps[num_steps][10]);
			if (n != 11 || num_steps == MAX_STEPS - 1) begin
				$display("Malformed or overlong stimulus file near step %0d", num_steps);
				$display("tests failed");
				$fatal(1, "Bad stimulus");
			end
			num_steps++;
		end
		$fclose(fd);
	endtask

	task automatic run_step(input int i);
		int gap;
		gap = $urandom % 4;  // Idle spacing between events
		repeat (gap) @(negedge clk_sys);
		@(negedge clk_sys);
		if (steps[i][2][0]) begin
			toggle  = ~toggle;  // Flip marks a new event
			ps2_key = {toggle, steps[i][1][0], 1'b0, steps[i][0][7:0]};
			repeat (3) @(negedge clk_sys);  // Capture then matrix update
		end
		addr      = steps[i][3][7:0];
		dragon    = steps[i][4][0];
		joy1_fire = steps[i][5][0];
		joy2_fire = steps[i][6][0];
		joy_hilo  = steps[i][7][0];
		#2;  // Scan path settles
		check_value("kb_rows", kb_rows, steps[i][8][15:0]);
		check_value("fn_keys", fn_keys, steps[i][9][15:0]);
		check_value("modif", modif, steps[i][10][15:0]);
	endtask

	initial begin
		void'($urandom(32'hdf3f));
		toggle    = 1'b0;
		ps2_key   = '0;
		addr      = '1;  // No column selected
		dragon    = 1'b0;
		joy1_fire = 1'b0;
		joy2_fire = 1'b0;
		joy_hilo  = 1'b0;
		rst_n     = 1'b0;
		load_trace();
		cycle_limit = RESET_CYCLES + 8 * num_steps + 50;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		for (int i = 0; i < num_steps; i++) begin
			run_step(i);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/coco_keyboard_assert.sv
`timescale 1ns/1ps
`default_nettype none

module coco_keyboard_assert (
	input logic                      clk_sys,
	input logic                      rst_n,
	input logic                      strobe,    // Internal event pulse
	input logic                      joy_hilo,
	input coco_kbd_pkg::matrix_row_t kb_rows,
	input coco_kbd_pkg::fn_keys_t    fn_keys
);

	// One pulse per toggle flip
	strobe_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		strobe |=> !strobe)
		else $error("strobe stayed high for two cycles");

	// Comparator bypasses the matrix
	hilo_pass: assert property (@(posedge clk_sys) disable iff (!rst_n)
		kb_rows[7] == joy_hilo)
		else $error("kb_rows bit 7 differs from joy_hilo");

	// Fn levels move only right after a strobe
	fn_after_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$past(strobe) |-> $stable(fn_keys))
		else $error("fn_keys changed without a strobe");

endmodule

bind coco_keyboard coco_keyboard_assert u_assert (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.strobe   (strobe),
	.joy_hilo (joy_hilo),
	.kb_rows  (kb_rows),
	.fn_keys  (fn_keys)
);

`default_nettype wire

// File: rtl/coco_keyboard.sv
`timescale 1ns/1ps
`default_nettype none

module coco_keyboard (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic [10:0]               ps2_key,  // Toggle-word event
	input  coco_kbd_pkg::matrix_row_t addr,
	input  logic                      dragon,  // Dragon row order
	input  logic                      joy1_fire,
	input  logic                      joy2_fire,
	input  logic                      joy_hilo,
	output coco_kbd_pkg::matrix_row_t kb_rows,
	output coco_kbd_pkg::fn_keys_t    fn_keys,
	output coco_kbd_pkg::modif_t      modif
);

	coco_kbd_pkg::scan_code_t code;
	logic                     pressed;
	logic                     strobe;
	coco_kbd_pkg::matrix_row_t [coco_kbd_pkg::NUM_ROWS-1:0] rows;

	kbd_event_capture u_capture (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ps2_key (ps2_key),
		.code    (code),
		.pressed (pressed),
		.strobe  (strobe)
	);

	key_matrix u_matrix (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.code    (code),
		.pressed (pressed),
		.strobe  (strobe),
		.rows    (rows)
	);

	fn_key_tracker u_fn (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.code    (code),
		.pressed (pressed),
		.strobe  (strobe),
		.fn_keys (fn_keys),
		.modif   (modif)
	);

	matrix_scan u_scan (
		.rows      (rows),
		.addr      (addr),
		.dragon    (dragon),
		.joy1_fire (joy1_fire),
		.joy2_fire (joy2_fire),
		.joy_hilo  (joy_hilo),
		.kb_rows   (kb_rows)
	);

endmodule

`default_nettype wire

// File: rtl/matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_scan (
	input  coco_kbd_pkg::matrix_row_t [coco_kbd_pkg::NUM_ROWS-1:0] rows,
	input  coco_kbd_pkg::matrix_row_t addr,  // Active low column selects
	input  logic                      dragon,
	input  logic                      joy1_fire,
	input  logic                      joy2_fire,
	input  logic                      joy_hilo,  // Joystick comparator
	output coco_kbd_pkg::matrix_row_t kb_rows
);

	coco_kbd_pkg::matrix_row_t [coco_kbd_pkg::NUM_ROWS-1:0] src_rows;  // Reordered
	logic [coco_kbd_pkg::NUM_ROWS-1:0] row_hit;

	////////////////////
	// Row order per machine
	always_comb begin
		src_rows = rows;  // CoCo order and the shared control row
		if (dragon) begin
			src_rows[0] = rows[4];  // Digits sit low on the Dragon
			src_rows[1] = rows[5];
			src_rows[2] = rows[0];  // Letters shift up by two
			src_rows[3] = rows[1];
			src_rows[4] = rows[2];
			src_rows[5] = rows[3];
		end
	end

	////////////////////
	// Column select and merge
	always_comb begin
		for (int r = 0; r < coco_kbd_pkg::NUM_ROWS; r++) begin
			row_hit[r] = |(~src_rows[r] & ~addr);  // Held key in a selected column
		end
	end

	assign kb_rows[0] = ~row_hit[0] & ~joy2_fire;
	assign kb_rows[1] = ~row_hit[1] & ~joy1_fire;
	assign kb_rows[6:2] = ~row_hit[6:2];
	assign kb_rows[7] = joy_hilo;  // Comparator passes straight through

endmodule

`default_nettype wire

// File: rtl/fn_key_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module fn_key_tracker (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  coco_kbd_pkg::scan_code_t code,
	input  logic                     pressed,
	input  logic                     strobe,
	output coco_kbd_pkg::fn_keys_t   fn_keys,  // Active high levels
	output coco_kbd_pkg::modif_t     modif
);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fn_keys <= '0;
			modif   <= '0;
		end else if (strobe) begin
			case (code)
				////////////////////
				// Modifiers
				coco_kbd_pkg::SC_RSHIFT: modif[0] <= pressed;  // Matrix sees it too
				coco_kbd_pkg::SC_ALT:    modif[1] <= pressed;
				coco_kbd_pkg::SC_CTRL:   modif[2] <= pressed;
				////////////////////
				// Function keys
				coco_kbd_pkg::SC_F1:  fn_keys[0]  <= pressed;
				coco_kbd_pkg::SC_F2:  fn_keys[1]  <= pressed;
				coco_kbd_pkg::SC_F3:  fn_keys[2]  <= pressed;
				coco_kbd_pkg::SC_F4:  fn_keys[3]  <= pressed;
				coco_kbd_pkg::SC_F5:  fn_keys[4]  <= pressed;
				coco_kbd_pkg::SC_F6:  fn_keys[5]  <= pressed;
				coco_kbd_pkg::SC_F7:  fn_keys[6]  <= pressed;
				coco_kbd_pkg::SC_F8:  fn_keys[7]  <= pressed;
				coco_kbd_pkg::SC_F9:  fn_keys[8]  <= pressed;
				coco_kbd_pkg::SC_F10: fn_keys[9]  <= pressed;
				coco_kbd_pkg::SC_F11: fn_keys[10] <= pressed;
				default: ;  // Everything else is matrix only
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/key_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module key_matrix (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  coco_kbd_pkg::scan_code_t code,
	input  logic                     pressed,
	input  logic                     strobe,
	output coco_kbd_pkg::matrix_row_t [coco_kbd_pkg::NUM_ROWS-1:0] rows  // Active low
);

	logic                   hit;
	coco_kbd_pkg::row_idx_t row;
	coco_kbd_pkg::col_idx_t col;
	logic                   force_shift;

	kbd_scancode_map u_map (
		.code        (code),
		.hit         (hit),
		.row         (row),
		.col         (col),
		.force_shift (force_shift)
	);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rows <= {coco_kbd_pkg::NUM_ROWS{coco_kbd_pkg::ROW_RELEASED}};  // All up
		end else if (strobe && hit) begin
			rows[row][col] <= ~pressed;  // Low while held
			if (force_shift) begin
				// Shift follows the keypad symbol
				rows[coco_kbd_pkg::SHIFT_ROW][coco_kbd_pkg::SHIFT_COL] <= ~pressed;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/kbd_scancode_map.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_scancode_map (
	input  coco_kbd_pkg::scan_code_t code,
	output logic                     hit,
	output coco_kbd_pkg::row_idx_t   row,
	output coco_kbd_pkg::col_idx_t   col,
	output logic                     force_shift
);

	logic [6:0] pos;  // {hit, row, col}

	always_comb begin
		case (code)
			////////////////////
			// Letters and @
			8'h54: pos = {1'b1, 3'd0, 3'd0};  // @
			8'h1C: pos = {1'b1, 3'd0, 3'd1};  // A
			8'h32: pos = {1'b1, 3'd0, 3'd2};  // B
			8'h21: pos = {1'b1, 3'd0, 3'd3};  // C
			8'h23: pos = {1'b1, 3'd0, 3'd4};  // D
			8'h24: pos = {1'b1, 3'd0, 3'd5};  // E
			8'h2B: pos = {1'b1, 3'd0, 3'd6};  // F
			8'h34: pos = {1'b1, 3'd0, 3'd7};  // G
			8'h33: pos = {1'b1, 3'd1, 3'd0};  // H
			8'h43: pos = {1'b1, 3'd1, 3'd1};  // I
			8'h3B: pos = {1'b1, 3'd1, 3'd2};  // J
			8'h42: pos = {1'b1, 3'd1, 3'd3};  // K
			8'h4B: pos = {1'b1, 3'd1, 3'd4};  // L
			8'h3A: pos = {1'b1, 3'd1, 3'd5};  // M
			8'h31: pos = {1'b1, 3'd1, 3'd6};  // N
			8'h44: pos = {1'b1, 3'd1, 3'd7};  // O
			8'h4D: pos = {1'b1, 3'd2, 3'd0};  // P
			8'h15: pos = {1'b1, 3'd2, 3'd1};  // Q
			8'h2D: pos = {1'b1, 3'd2, 3'd2};  // R
			8'h1B: pos = {1'b1, 3'd2, 3'd3};  // S
			8'h2C: pos = {1'b1, 3'd2, 3'd4};  // T
			8'h3C: pos = {1'b1, 3'd2, 3'd5};  // U
			8'h2A: pos = {1'b1, 3'd2, 3'd6};  // V
			8'h1D: pos = {1'b1, 3'd2, 3'd7};  // W
			8'h22: pos = {1'b1, 3'd3, 3'd0};  // X
			8'h35: pos = {1'b1, 3'd3, 3'd1};  // Y
			8'h1A: pos = {1'b1, 3'd3, 3'd2};  // Z
			////////////////////
			// Cursor keys and space share row 3
			8'h75: pos = {1'b1, 3'd3, 3'd3};  // Up
			8'h72: pos = {1'b1, 3'd3, 3'd4};  // Down
			8'h6B: pos = {1'b1, 3'd3, 3'd5};  // Left
			8'h66: pos = {1'b1, 3'd3, 3'd5};  // Backspace acts as left
			8'h74: pos = {1'b1, 3'd3, 3'd6};  // Right
			8'h29: pos = {1'b1, 3'd3, 3'd7};  // Space
			////////////////////
			// Digits and punctuation
			8'h45: pos = {1'b1, 3'd4, 3'd0};  // 0
			8'h16: pos = {1'b1, 3'd4, 3'd1};  // 1
			8'h1E: pos = {1'b1, 3'd4, 3'd2};  // 2
			8'h26: pos = {1'b1, 3'd4, 3'd3};  // 3
			8'h25: pos = {1'b1, 3'd4, 3'd4};  // 4
			8'h2E: pos = {1'b1, 3'd4, 3'd5};  // 5
			8'h36: pos = {1'b1, 3'd4, 3'd6};  // 6
			8'h3D: pos = {1'b1, 3'd4, 3'd7};  // 7
			8'h3E: pos = {1'b1, 3'd5, 3'd0};  // 8
			8'h46: pos = {1'b1, 3'd5, 3'd1};  // 9
			8'h4E: pos = {1'b1, 3'd5, 3'd2};  // PC minus gives colon
			8'h4C: pos = {1'b1, 3'd5, 3'd3};  // Semicolon
			8'h41: pos = {1'b1, 3'd5, 3'd4};  // Comma
			8'h55: pos = {1'b1, 3'd5, 3'd5};  // PC equals gives minus
			8'h49: pos = {1'b1, 3'd5, 3'd6};  // Period
			8'h4A: pos = {1'b1, 3'd5, 3'd7};  // Slash
			////////////////////
			// Control row
			8'h5A: pos = {1'b1, 3'd6, 3'd0};  // Enter
			8'h0D: pos = {1'b1, 3'd6, 3'd1};  // Tab as clear
			8'h76: pos = {1'b1, 3'd6, 3'd2};  // Escape as break
			coco_kbd_pkg::SC_LSHIFT: pos = {1'b1, coco_kbd_pkg::SHIFT_ROW, coco_kbd_pkg::SHIFT_COL};
			coco_kbd_pkg::SC_RSHIFT: pos = {1'b1, coco_kbd_pkg::SHIFT_ROW, coco_kbd_pkg::SHIFT_COL};
			// Keypad
			8'h7B: pos = {1'b1, 3'd5, 3'd5};  // Keypad minus
			8'h6C: pos = {1'b1, 3'd6, 3'd1};  // Keypad 7 as clear
			coco_kbd_pkg::SC_KP_STAR: pos = {1'b1, 3'd5, 3'd2};  // Colon plus shift
			coco_kbd_pkg::SC_KP_PLUS: pos = {1'b1, 3'd5, 3'd3};  // Semicolon plus shift
			default: pos = 7'd0;  // Unmapped, 0x52 among them
		endcase
	end

	assign hit = pos[6];
	assign row = pos[5:3];
	assign col = pos[2:0];

	// Keypad symbols live on shifted keys
	assign force_shift = (code == coco_kbd_pkg::SC_KP_STAR) ||
	                     (code == coco_kbd_pkg::SC_KP_PLUS);

endmodule

`default_nettype wire

// File: rtl/kbd_event_capture.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_event_capture (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic [10:0]              ps2_key,  // Toggle, pressed, ext, code
	output coco_kbd_pkg::scan_code_t code,
	output logic                     pressed,
	output logic                     strobe
);

	logic toggle_q;  // Last seen toggle bit
	logic new_event;

	assign new_event = ps2_key[10] ^ toggle_q;  // Flip means a fresh event

	// Control state
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			toggle_q <= 1'b0;
			strobe   <= 1'b0;
		end else begin
			toggle_q <= ps2_key[10];
			strobe   <= new_event;  // One cycle per flip
		end
	end

	// Event payload, bit 8 (extended) dropped
	always_ff @(posedge clk_sys) begin
		if (new_event) begin
			code    <= ps2_key[7:0];
			pressed <= ps2_key[9];
		end
	end

endmodule

`default_nettype wire

// File: rtl/coco_kbd_pkg.sv
`default_nettype none

package coco_kbd_pkg;

	typedef logic [7:0]  scan_code_t;   // PS/2 set 2 code
	typedef logic [7:0]  matrix_row_t;  // Active low, one bit per column
	typedef logic [2:0]  row_idx_t;     // Matrix row number
	typedef logic [2:0]  col_idx_t;     // Matrix column number
	typedef logic [10:0] fn_keys_t;     // Bit 0 is F1
	typedef logic [2:0]  modif_t;       // Rshift, alt, ctrl

	////////////////////
	// Matrix geometry
	localparam int          NUM_ROWS     = 7;
	localparam row_idx_t    SHIFT_ROW    = 3'd6;
	localparam col_idx_t    SHIFT_COL    = 3'd7;
	localparam matrix_row_t ROW_RELEASED = 8'hFF;  // No key down

	////////////////////
	// Scancodes shared between the map and the tracker
	localparam scan_code_t SC_LSHIFT  = 8'h12;
	localparam scan_code_t SC_RSHIFT  = 8'h59;
	localparam scan_code_t SC_ALT     = 8'h11;
	localparam scan_code_t SC_CTRL    = 8'h14;
	localparam scan_code_t SC_F1      = 8'h05;
	localparam scan_code_t SC_F2      = 8'h06;
	localparam scan_code_t SC_F3      = 8'h04;
	localparam scan_code_t SC_F4      = 8'h0C;
	localparam scan_code_t SC_F5      = 8'h03;
	localparam scan_code_t SC_F6      = 8'h0B;
	localparam scan_code_t SC_F7      = 8'h83;  // Odd one out in set 2
	localparam scan_code_t SC_F8      = 8'h0A;
	localparam scan_code_t SC_F9      = 8'h01;
	localparam scan_code_t SC_F10     = 8'h09;
	localparam scan_code_t SC_F11     = 8'h78;
	localparam scan_code_t SC_KP_STAR = 8'h7C;  // Shifted colon on the machine
	localparam scan_code_t SC_KP_PLUS = 8'h79;  // Shifted semicolon

endpackage

`default_nettype wire
